//--- list.f
hw/dmaPkg.sv
hw/dualPortRam.sv
hw/ciDecoder.sv
hw/dmaEngine.sv
hw/busInterface.sv
hw/sobelDma.sv
bench/busSlaveModel.sv
bench/sobelDmaTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module sobelDmaTb \
  -Mdir obj_dir -o simv

# The simulator exits nonzero on a fatal error, so its status is judged from the log
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

//--- bench/sobelDmaTb.sv
`timescale 1ns/100ps

module sobelDmaTb;
  import dmaPkg::*;

  localparam int numTransfers = 5;

  logic        clock = 1'b0;
  logic        reset;
  logic        start;
  logic [7:0]  ciN;
  logic [31:0] valueA;
  logic [31:0] valueB;
  logic        done;
  logic [31:0] result;
  logic        requestTransaction;
  logic        transactionGranted;
  logic        endTransactionIn;
  logic        dataValidIn;
  logic        busErrorIn;
  logic        busyIn;
  logic [31:0] addressDataIn;
  logic        beginTransactionOut;
  logic        readNotWriteOut;
  logic        endTransactionOut;
  logic        dataValidOut;
  logic [3:0]  byteEnablesOut;
  logic [7:0]  burstSizeOut;
  logic [31:0] addressDataOut;
  logic        errorInject;

  // Reference model of the SRAM, the slave memory and the configuration registers
  logic [31:0] sramModel [512];
  logic [31:0] busMem [1024];
  logic [31:0] busAddrM;
  int          ramAddrM;
  int          blockM;
  int          burstM;
  int          blocks [numTransfers];
  int          plannedCycles;

  sobelDma u_sobelDma (
    .clock(clock), .reset(reset), .start(start), .ciN(ciN), .valueA(valueA),
    .valueB(valueB), .done(done), .result(result),
    .requestTransaction(requestTransaction), .transactionGranted(transactionGranted),
    .endTransactionIn(endTransactionIn), .dataValidIn(dataValidIn),
    .busErrorIn(busErrorIn), .busyIn(busyIn), .addressDataIn(addressDataIn),
    .beginTransactionOut(beginTransactionOut), .readNotWriteOut(readNotWriteOut),
    .endTransactionOut(endTransactionOut), .dataValidOut(dataValidOut),
    .byteEnablesOut(byteEnablesOut), .burstSizeOut(burstSizeOut),
    .addressDataOut(addressDataOut)
  );

  busSlaveModel u_busSlaveModel (
    .clock(clock), .reset(reset), .injectError(errorInject),
    .requestTransaction(requestTransaction), .beginTransactionOut(beginTransactionOut),
    .readNotWriteOut(readNotWriteOut), .endTransactionOut(endTransactionOut),
    .dataValidOut(dataValidOut), .byteEnablesOut(byteEnablesOut),
    .burstSizeOut(burstSizeOut), .addressDataOut(addressDataOut),
    .transactionGranted(transactionGranted), .endTransactionIn(endTransactionIn),
    .dataValidIn(dataValidIn), .busErrorIn(busErrorIn), .busyIn(busyIn),
    .addressDataIn(addressDataIn)
  );

  always #10 clock = ~clock;

  task automatic checkEqual(string what, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("TB FAILED");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  function automatic logic [31:0] opField(ciOp op);
    return 32'(op) << 9;
  endfunction

  task automatic issueWrite(logic [31:0] a, logic [31:0] b);
    start  = 1'b1;
    ciN    = customId;
    valueA = a;
    valueB = b;
    #1;
    checkEqual("done on a write", 32'(done), 32'd1);  // Same cycle as start
    @(negedge clock);
    start  = 1'b0;
    valueA = '0;
    valueB = '0;
  endtask

  task automatic issueRead(logic [2:0] sel, logic [8:0] addr, output logic [31:0] data);
    start  = 1'b1;
    ciN    = customId;
    valueA = {19'd0, sel, 1'b0, addr};
    valueB = '0;
    @(negedge clock);
    start  = 1'b0;
    valueA = '0;
    checkEqual("done on a read", 32'(done), 32'd1);
    data = result;
  endtask

  task automatic configure(logic [31:0] bus, logic [31:0] ram, logic [31:0] block,
                           logic [31:0] burst);
    issueWrite(opField(setBusAddr), bus);
    issueWrite(opField(setRamAddr), ram);
    issueWrite(opField(setBlock), block);
    issueWrite(opField(setBurst), burst);
    busAddrM = bus;
    ramAddrM = int'(ram[8:0]);
    blockM   = int'(block[9:0]);
    burstM   = int'(burst[7:0]);
  endtask

  task automatic checkRegisters();
    logic [31:0] v;
    issueRead(selBusAddr, 9'd0, v);
    checkEqual("bus address register", v, busAddrM);
    issueRead(selRamAddr, 9'd0, v);
    checkEqual("SRAM address register", v, 32'(ramAddrM));
    issueRead(selBlock, 9'd0, v);
    checkEqual("block size register", v, 32'(blockM));
    issueRead(selBurst, 9'd0, v);
    checkEqual("burst size register", v, 32'(burstM));
  endtask

  task automatic randomConfig(int block);
    logic [31:0] burst;
    burst = ($urandom_range(0, 3) == 0) ? $urandom_range(8, 60) : $urandom_range(0, 7);
    configure($urandom, $urandom_range(0, 511), 32'(block), burst);
  endtask

  task automatic waitIdle(output logic [31:0] status);
    do
      issueRead(selStatus, 9'd0, status);
    while (status[0]);
  endtask

  task automatic moveModel(bit toSram, logic [31:0] bus, int ram, int block);
    int w;
    int r;
    for (int k = 0; k < block; k++)
    begin
      w = (int'(bus[11:2]) + k) % 1024;
      r = (ram + k) % 512;
      if (toSram)
        sramModel[r] = busMem[w];
      else
        busMem[w] = sramModel[r];
    end
  endtask

  // Burst split rule applied to the configuration of one transfer
  task automatic checkBursts(int first, bit rnw, logic [31:0] bus, int block, int burst);
    int          idx;
    int          r;
    int          n;
    logic [31:0] addr;
    idx  = first;
    r    = block;
    addr = {bus[31:2], 2'b00};
    while (r > 0)
    begin
      n = (r > burst + 1) ? burst + 1 : r;
      checkEqual("burst present", 32'(idx < u_busSlaveModel.burstAddrQ.size()), 32'd1);
      checkEqual("burst address", u_busSlaveModel.burstAddrQ[idx], addr);
      checkEqual("burst size", 32'(u_busSlaveModel.burstSizeQ[idx]), 32'(n - 1));
      checkEqual("burst direction", 32'(u_busSlaveModel.burstRnwQ[idx]), 32'(rnw));
      addr += 32'(4 * n);
      r    -= n;
      idx++;
    end
    checkEqual("number of bursts", 32'(u_busSlaveModel.burstAddrQ.size()), 32'(idx));
  endtask

  task automatic checkSlaveMem();
    for (int i = 0; i < 1024; i++)
      checkEqual("slave memory word", u_busSlaveModel.mem[i], busMem[i]);
  endtask

  task automatic checkSram(int first, int count);
    logic [31:0] v;
    int          a;
    for (int k = 0; k < count; k++)
    begin
      a = (first + k) % 512;
      issueRead(selSram, 9'(a), v);
      checkEqual("SRAM word", v, sramModel[a]);
    end
  endtask

  task automatic runTransfer(bit toSram, logic [31:0] expStatus);
    int          first;
    logic [31:0] status;
    first = u_busSlaveModel.burstAddrQ.size();
    issueWrite(opField(dmaControl), toSram ? 32'd1 : 32'd2);
    waitIdle(status);
    checkEqual("status after transfer", status, expStatus);
    if (expStatus == 32'd0)
    begin
      moveModel(toSram, busAddrM, ramAddrM, blockM);
      checkBursts(first, toSram, busAddrM, blockM, burstM);
    end
  endtask

  initial
  begin
    wait (plannedCycles != 0);
    repeat (plannedCycles) @(posedge clock);
    $display("Timeout: the run did not finish within %0d clock cycles", plannedCycles);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

  initial
  begin
    int          sum;
    int          first;
    logic [31:0] v;
    logic [31:0] a;
    logic [31:0] savedBus;
    int          savedRam;
    int          savedBlock;
    int          savedBurst;
    void'($urandom(32'hd8db_8a66));
    reset       = 1'b1;
    start       = 1'b0;
    ciN         = '0;
    valueA      = '0;
    valueB      = '0;
    errorInject = 1'b0;
    sum = 0;
    for (int i = 0; i < numTransfers; i++)
    begin
      blocks[i] = $urandom_range(1, 48);
      sum += blocks[i];
    end
    plannedCycles = 40 * sum + 8000;  // Fixed part covers the SRAM fill and readback
    repeat (16) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < 1024; i++)
      busMem[i] = u_busSlaveModel.mem[i];

    checkEqual("control outputs after reset", {26'd0, requestTransaction,
      beginTransactionOut, endTransactionOut, dataValidOut, done, |result}, 32'd0);
    issueRead(selStatus, 9'd0, v);
    checkEqual("status after reset", v, 32'd0);
    repeat (6)
    begin
      configure($urandom, $urandom, $urandom, $urandom);
      checkRegisters();
    end

    for (int i = 0; i < 512; i++)
    begin
      v = $urandom;
      issueWrite(opField(sramWrite) | 32'(i), v);
      sramModel[i] = v;
    end
    repeat (40)
    begin
      a = opField(sramWrite) | $urandom_range(0, 511) | ($urandom_range(1, 524287) << 13);
      issueWrite(a, $urandom);  // Dropped by the decoder
    end
    repeat (64)
      checkSram($urandom_range(0, 511), 1);

    randomConfig(blocks[0]);
    runTransfer(1'b1, 32'd0);
    checkSram(ramAddrM, blockM);
    randomConfig(blocks[1]);
    runTransfer(1'b0, 32'd0);
    checkSlaveMem();

    randomConfig(blocks[2]);
    errorInject = 1'b1;
    runTransfer(1'b1, 32'd2);
    errorInject = 1'b0;
    randomConfig(blocks[3]);
    runTransfer(1'b1, 32'd0);  // Error flag cleared by this start
    checkSram(ramAddrM, blockM);

    randomConfig(blocks[4]);
    savedBus   = busAddrM;
    savedRam   = ramAddrM;
    savedBlock = blockM;
    savedBurst = burstM;
    first      = u_busSlaveModel.burstAddrQ.size();
    issueWrite(opField(dmaControl), 32'd2);
    issueWrite(opField(dmaControl), 32'd1);
    randomConfig($urandom_range(1, 48));
    waitIdle(v);
    checkEqual("status after transfer", v, 32'd0);
    moveModel(1'b0, savedBus, savedRam, savedBlock);
    checkBursts(first, 1'b0, savedBus, savedBlock, savedBurst);
    checkSlaveMem();
    checkRegisters();

    checkSram(0, 512);
    checkEqual("slave protocol errors", 32'(u_busSlaveModel.protocolErrors), 32'd0);
    $display("TB PASSED");
    $finish;
  end

endmodule

//--- bench/busSlaveModel.sv
`timescale 1ns/100ps

module busSlaveModel (
  input  logic        clock,
  input  logic        reset,
  input  logic        injectError,
  input  logic        requestTransaction,
  input  logic        beginTransactionOut,
  input  logic        readNotWriteOut,
  input  logic        endTransactionOut,
  input  logic        dataValidOut,
  input  logic [3:0]  byteEnablesOut,
  input  logic [7:0]  burstSizeOut,
  input  logic [31:0] addressDataOut,
  output logic        transactionGranted,
  output logic        endTransactionIn,
  output logic        dataValidIn,
  output logic        busErrorIn,
  output logic        busyIn,
  output logic [31:0] addressDataIn
);

  logic [31:0] mem [1024];
  logic [31:0] burstAddrQ [$];
  int          burstSizeQ [$];
  logic        burstRnwQ [$];
  int          protocolErrors;

  initial
  begin
    int   word;
    int   n;
    int   got;
    logic busyNext;
    logic endSent;
    protocolErrors     = 0;
    transactionGranted = 1'b0;
    endTransactionIn   = 1'b0;
    dataValidIn        = 1'b0;
    busErrorIn         = 1'b0;
    busyIn             = 1'b0;
    addressDataIn      = '0;
    for (int i = 0; i < 1024; i++)
      mem[i] = 32'h5a3c_0000 ^ (32'(i) * 32'h9e37_79b1);  // Every word differs
    forever
    begin
      @(negedge clock);
      if (dataValidOut)
        protocolErrors++;  // Write beat outside any burst
      if (!reset && requestTransaction)
      begin
        repeat ($urandom_range(0, 3)) @(negedge clock);
        transactionGranted = 1'b1;
        @(negedge clock);
        transactionGranted = 1'b0;
        while (!beginTransactionOut)
          @(negedge clock);
        if (byteEnablesOut != 4'hF)
          protocolErrors++;
        burstAddrQ.push_back(addressDataOut);
        burstSizeQ.push_back(int'(burstSizeOut));
        burstRnwQ.push_back(readNotWriteOut);
        word = int'(addressDataOut[11:2]);
        n    = int'(burstSizeOut) + 1;
        if (readNotWriteOut)
        begin
          endSent = 1'b0;
          for (int i = 0; i < n; i++)
          begin
            @(negedge clock);
            dataValidIn      = 1'b0;
            endTransactionIn = 1'b0;
            repeat ($urandom_range(0, 2)) @(negedge clock);
            if (injectError)
            begin
              busErrorIn = 1'b1;  // Abort the burst without data
              endSent    = 1'b0;
              break;
            end
            dataValidIn      = 1'b1;
            addressDataIn    = mem[10'(word + i)];
            endTransactionIn = (i == n - 1) && ($urandom_range(0, 1) == 1);
            endSent          = endTransactionIn;
          end
          @(negedge clock);
          dataValidIn      = 1'b0;
          endTransactionIn = 1'b0;
          busErrorIn       = 1'b0;
          addressDataIn    = '0;
          if (!endSent)
          begin
            repeat ($urandom_range(0, 2)) @(negedge clock);
            endTransactionIn = 1'b1;
            @(negedge clock);
            endTransactionIn = 1'b0;
          end
        end
        else
        begin
          got = 0;
          while (got < n)
          begin
            busyNext = ($urandom_range(0, 3) == 0);
            if (dataValidOut && !busyNext)
            begin
              mem[10'(word + got)] = addressDataOut;
              got++;
            end
            busyIn = busyNext;
            @(negedge clock);
          end
          busyIn = 1'b0;
          while (!endTransactionOut)
          begin
            if (dataValidOut)
              protocolErrors++;  // More beats than the burst announced
            @(negedge clock);
          end
        end
      end
    end
  end

endmodule

//--- hw/sobelDma.sv
`timescale 1ns/100ps

module sobelDma (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          start,
  input  logic [7:0]                    ciN,
  input  logic [31:0]                   valueA,
  input  logic [31:0]                   valueB,
  output logic                          done,
  output logic [31:0]                   result,
  output logic                          requestTransaction,
  input  logic                          transactionGranted,
  input  logic                          endTransactionIn,
  input  logic                          dataValidIn,
  input  logic                          busErrorIn,
  input  logic                          busyIn,
  input  logic [31:0]                   addressDataIn,
  output logic                          beginTransactionOut,
  output logic                          readNotWriteOut,
  output logic                          endTransactionOut,
  output logic                          dataValidOut,
  output logic [3:0]                    byteEnablesOut,
  output logic [dmaPkg::burstWidth-1:0] burstSizeOut,
  output logic [31:0]                   addressDataOut
);
  import dmaPkg::*;

  logic [ramAddrWidth-1:0] ciRamAddr;
  logic                    ciRamWriteEnable;
  logic [31:0]             ciRamWriteData;
  logic [31:0]             ciRamReadData;
  logic [ramAddrWidth-1:0] dmaRamAddr;
  logic                    dmaRamWriteEnable;
  logic [31:0]             dmaRamWriteData;
  logic [31:0]             dmaRamReadData;
  logic [31:0]             busStartAddr;
  logic [ramAddrWidth-1:0] ramStartAddr;
  logic [blockWidth-1:0]   blockSize;
  logic [burstWidth-1:0]   burstSize;
  logic                    startRead;
  logic                    startWrite;
  logic                    busy;
  logic                    busError;
  logic                    setUp;
  logic                    readNotWrite;
  logic [31:0]             burstAddr;
  logic [burstWidth-1:0]   beats;
  logic                    writeBeat;
  logic [31:0]             writeData;
  logic                    endPulse;
  logic                    readValid;
  logic [31:0]             readData;
  logic                    readEnd;

  ciDecoder u_ciDecoder (
    .clock(clock), .reset(reset), .start(start), .ciN(ciN),
    .valueA(valueA), .valueB(valueB), .ramReadData(ciRamReadData),
    .busy(busy), .busError(busError), .done(done), .result(result),
    .ramAddr(ciRamAddr), .ramWriteEnable(ciRamWriteEnable),
    .ramWriteData(ciRamWriteData), .busStartAddr(busStartAddr),
    .ramStartAddr(ramStartAddr), .blockSize(blockSize), .burstSize(burstSize),
    .startRead(startRead), .startWrite(startWrite)
  );

  // Port A serves the processor, port B the engine
  dualPortRam #(.width(32), .depth(ramDepth)) u_dualPortRam (
    .clock(clock),
    .writeEnableA(ciRamWriteEnable), .addressA(ciRamAddr),
    .dataInA(ciRamWriteData), .dataOutA(ciRamReadData),
    .writeEnableB(dmaRamWriteEnable), .addressB(dmaRamAddr),
    .dataInB(dmaRamWriteData), .dataOutB(dmaRamReadData)
  );

  dmaEngine u_dmaEngine (
    .clock(clock), .reset(reset), .busStartAddr(busStartAddr),
    .ramStartAddr(ramStartAddr), .blockSize(blockSize), .burstSize(burstSize),
    .startRead(startRead), .startWrite(startWrite),
    .transactionGranted(transactionGranted), .readValid(readValid),
    .readData(readData), .readEnd(readEnd), .busErrorIn(busErrorIn),
    .busyIn(busyIn), .ramReadData(dmaRamReadData), .busy(busy),
    .busError(busError), .requestTransaction(requestTransaction),
    .setUp(setUp), .readNotWrite(readNotWrite), .burstAddr(burstAddr),
    .beats(beats), .writeBeat(writeBeat), .writeData(writeData),
    .endPulse(endPulse), .ramAddr(dmaRamAddr),
    .ramWriteEnable(dmaRamWriteEnable), .ramWriteData(dmaRamWriteData)
  );

  busInterface u_busInterface (
    .clock(clock), .reset(reset), .setUp(setUp), .readNotWrite(readNotWrite),
    .burstAddr(burstAddr), .beats(beats), .writeBeat(writeBeat),
    .writeData(writeData), .endPulse(endPulse), .busyIn(busyIn),
    .endTransactionIn(endTransactionIn), .dataValidIn(dataValidIn),
    .addressDataIn(addressDataIn), .readValid(readValid), .readData(readData),
    .readEnd(readEnd), .beginTransactionOut(beginTransactionOut),
    .readNotWriteOut(readNotWriteOut), .endTransactionOut(endTransactionOut),
    .dataValidOut(dataValidOut), .byteEnablesOut(byteEnablesOut),
    .burstSizeOut(burstSizeOut), .addressDataOut(addressDataOut)
  );

endmodule

//--- hw/busInterface.sv
`timescale 1ns/100ps

module busInterface (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          setUp,
  input  logic                          readNotWrite,
  input  logic [31:0]                   burstAddr,
  input  logic [dmaPkg::burstWidth-1:0] beats,
  input  logic                          writeBeat,
  input  logic [31:0]                   writeData,
  input  logic                          endPulse,
  input  logic                          busyIn,
  input  logic                          endTransactionIn,
  input  logic                          dataValidIn,
  input  logic [31:0]                   addressDataIn,
  output logic                          readValid,
  output logic [31:0]                   readData,
  output logic                          readEnd,
  output logic                          beginTransactionOut,
  output logic                          readNotWriteOut,
  output logic                          endTransactionOut,
  output logic                          dataValidOut,
  output logic [3:0]                    byteEnablesOut,
  output logic [dmaPkg::burstWidth-1:0] burstSizeOut,
  output logic [31:0]                   addressDataOut
);

  logic holdBeat;

  // A beat stays on the bus until the slave drops busy
  assign holdBeat = busyIn && dataValidOut;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      readValid           <= 1'b0;
      readEnd             <= 1'b0;
      beginTransactionOut <= 1'b0;
      readNotWriteOut     <= 1'b0;
      byteEnablesOut      <= 4'h0;
      burstSizeOut        <= '0;
      endTransactionOut   <= 1'b0;
      dataValidOut        <= 1'b0;
    end
    else
    begin
      readValid           <= dataValidIn;
      readEnd             <= endTransactionIn;
      beginTransactionOut <= setUp;
      readNotWriteOut     <= setUp && readNotWrite;
      byteEnablesOut      <= setUp ? 4'hF : 4'h0;
      burstSizeOut        <= setUp ? beats : '0;
      endTransactionOut   <= endPulse;
      if (!holdBeat)
        dataValidOut <= writeBeat;
    end
  end

  always_ff @(posedge clock)
  begin
    readData <= addressDataIn;
    if (holdBeat)
      addressDataOut <= addressDataOut;
    else if (setUp)
      addressDataOut <= burstAddr;  // Address phase
    else if (writeBeat)
      addressDataOut <= writeData;
    else
      addressDataOut <= '0;
  end

  holdWhileBusy: assert property (@(posedge clock) disable iff (reset)
    holdBeat |-> !writeBeat)
    else $error("new write beat handed over while the slave was busy");

endmodule

//--- hw/dmaEngine.sv
`timescale 1ns/100ps

module dmaEngine (
  input  logic                            clock,
  input  logic                            reset,
  input  logic [31:0]                     busStartAddr,
  input  logic [dmaPkg::ramAddrWidth-1:0] ramStartAddr,
  input  logic [dmaPkg::blockWidth-1:0]   blockSize,
  input  logic [dmaPkg::burstWidth-1:0]   burstSize,
  input  logic                            startRead,
  input  logic                            startWrite,
  input  logic                            transactionGranted,
  input  logic                            readValid,
  input  logic [31:0]                     readData,
  input  logic                            readEnd,
  input  logic                            busErrorIn,
  input  logic                            busyIn,
  input  logic [31:0]                     ramReadData,
  output logic                            busy,
  output logic                            busError,
  output logic                            requestTransaction,
  output logic                            setUp,
  output logic                            readNotWrite,
  output logic [31:0]                     burstAddr,
  output logic [dmaPkg::burstWidth-1:0]   beats,
  output logic                            writeBeat,
  output logic [31:0]                     writeData,
  output logic                            endPulse,
  output logic [dmaPkg::ramAddrWidth-1:0] ramAddr,
  output logic                            ramWriteEnable,
  output logic [31:0]                     ramWriteData
);
  import dmaPkg::*;

  dmaState                 state;
  dmaState                 nextState;
  logic                    isReadReg;
  logic                    busErrorReg;
  logic [31:0]             busAddr;
  logic [ramAddrWidth-1:0] ramPtr;
  logic [blockWidth-1:0]   remaining;
  logic [burstWidth-1:0]   burstShadow;
  logic [burstWidth:0]     owed;  // Beats still to issue, minus one; MSB set when none left
  logic [blockWidth-1:0]   maxBeats;
  logic [blockWidth-1:0]   remainingLess;
  logic                    wordStep;
  logic                    dmaDone;

  // A last beat arriving with end of transaction also completes the block
  assign dmaDone = (remaining == '0) ||
                   ((remaining == blockWidth'(1)) && readEnd && readValid);

  always_comb
  begin
    case (state)
      idle:       nextState = (startRead || startWrite) ? init : idle;
      init:       nextState = (blockSize == '0) ? idle : requestBus;
      requestBus: nextState = transactionGranted ? dmaPkg::setUp : requestBus;
      dmaPkg::setUp:
        nextState = isReadReg ? doRead : doWrite;
      doRead:
      begin
        if (busErrorIn)
          nextState = readEnd ? idle : waitEnd;
        else if (readEnd)
          nextState = dmaDone ? idle : requestBus;
        else
          nextState = doRead;
      end
      waitEnd:    nextState = readEnd ? idle : waitEnd;
      doWrite:
      begin
        if (busErrorIn)
          nextState = endError;
        else if (owed[burstWidth] && !busyIn)
          nextState = endWrite;  // Last beat has been taken
        else
          nextState = doWrite;
      end
      endWrite:   nextState = (remaining == '0) ? idle : requestBus;
      default:    nextState = idle;
    endcase
  end

  assign maxBeats      = blockWidth'(burstShadow) + 1'b1;
  assign remainingLess = remaining - 1'b1;
  assign beats         = (remaining > maxBeats) ? burstShadow : remainingLess[burstWidth-1:0];

  assign ramWriteEnable = (state == doRead) && readValid;
  assign ramWriteData   = readData;
  assign writeBeat      = (state == doWrite) && !busyIn && !owed[burstWidth];
  assign writeData      = ramReadData;
  assign wordStep       = ramWriteEnable || writeBeat;

  // Port B looks one word ahead during writes to hide the read latency
  assign ramAddr = writeBeat ? ramPtr + 1'b1 : ramPtr;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state       <= idle;
      isReadReg   <= 1'b0;
      busErrorReg <= 1'b0;
      remaining   <= '0;
      owed        <= '0;
    end
    else
    begin
      state <= nextState;
      if (state == idle)
        isReadReg <= startRead;
      if (state == init)
        busErrorReg <= 1'b0;
      else if ((state == doRead || state == doWrite) && busErrorIn)
        busErrorReg <= 1'b1;
      if (state == init)
        remaining <= blockSize;
      else if (wordStep)
        remaining <= remainingLess;
      if (state == dmaPkg::setUp)
        owed <= {1'b0, beats};
      else if (writeBeat)
        owed <= owed - 1'b1;
    end
  end

  always_ff @(posedge clock)
  begin
    if (state == init)
    begin
      busAddr     <= busStartAddr;
      ramPtr      <= ramStartAddr;
      burstShadow <= burstSize;
    end
    else if (wordStep)
    begin
      busAddr <= busAddr + 32'd4;
      ramPtr  <= ramPtr + 1'b1;
    end
  end

  assign busy               = (state != idle);
  assign busError           = busErrorReg;
  assign requestTransaction = (state == requestBus);
  assign setUp              = (state == dmaPkg::setUp);
  assign readNotWrite       = isReadReg;
  assign burstAddr          = {busAddr[31:2], 2'b00};
  assign endPulse           = (state == endError) || (state == endWrite);

  noUnderflow: assert property (@(posedge clock) disable iff (reset)
    wordStep |-> remaining != '0)
    else $error("remaining word count underflow");

  beatInWrite: assert property (@(posedge clock) disable iff (reset)
    writeBeat |-> !isReadReg)
    else $error("write beat outside a write burst");

endmodule

//--- hw/ciDecoder.sv
`timescale 1ns/100ps

module ciDecoder (
  input  logic                            clock,
  input  logic                            reset,
  input  logic                            start,
  input  logic [7:0]                      ciN,
  input  logic [31:0]                     valueA,
  input  logic [31:0]                     valueB,
  input  logic [31:0]                     ramReadData,
  input  logic                            busy,
  input  logic                            busError,
  output logic                            done,
  output logic [31:0]                     result,
  output logic [dmaPkg::ramAddrWidth-1:0] ramAddr,
  output logic                            ramWriteEnable,
  output logic [31:0]                     ramWriteData,
  output logic [31:0]                     busStartAddr,
  output logic [dmaPkg::ramAddrWidth-1:0] ramStartAddr,
  output logic [dmaPkg::blockWidth-1:0]   blockSize,
  output logic [dmaPkg::burstWidth-1:0]   burstSize,
  output logic                            startRead,
  output logic                            startWrite
);
  import dmaPkg::*;

  logic        isMyCi;
  ciOp         op;
  logic        isRead;
  logic        readStrobeReg;
  logic [2:0]  readSelReg;
  logic [31:0] readValue;

  assign isMyCi = start && (ciN == customId);
  assign op     = ciOp'(valueA[12:9]);
  assign isRead = isMyCi && !valueA[9];

  // Stores are dropped unless the upper address bits are clear
  assign ramAddr        = valueA[ramAddrWidth-1:0];
  assign ramWriteData   = valueB;
  assign ramWriteEnable = isMyCi && (valueA[31:10] == '0) && (op == sramWrite);

  assign startRead  = isMyCi && (op == dmaControl) && (valueB[1:0] == 2'b01) && !busy;
  assign startWrite = isMyCi && (op == dmaControl) && (valueB[1:0] == 2'b10) && !busy;

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      busStartAddr <= '0;
      ramStartAddr <= '0;
      blockSize    <= '0;
      burstSize    <= '0;
    end
    else if (isMyCi)
    begin
      case (op)
        setBusAddr: busStartAddr <= valueB;
        setRamAddr: ramStartAddr <= valueB[ramAddrWidth-1:0];
        setBlock:   blockSize    <= valueB[blockWidth-1:0];
        setBurst:   burstSize    <= valueB[burstWidth-1:0];
        default:    ;
      endcase
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      readStrobeReg <= 1'b0;
    end
    else
    begin
      readStrobeReg <= isRead;
    end
  end

  always_ff @(posedge clock)
  begin
    readSelReg <= valueA[12:10];
  end

  always_comb
  begin
    case (readSelReg)
      selSram:    readValue = ramReadData;
      selBusAddr: readValue = busStartAddr;
      selRamAddr: readValue = 32'(ramStartAddr);
      selBlock:   readValue = 32'(blockSize);
      selBurst:   readValue = 32'(burstSize);
      selStatus:  readValue = {30'd0, busError, busy};
      default:    readValue = '0;
    endcase
  end

  assign done   = (isMyCi && valueA[9]) || readStrobeReg;  // Writes finish at once
  assign result = readStrobeReg ? readValue : '0;

  startTaken: assert property (@(posedge clock) disable iff (reset)
    (startRead || startWrite) |=> busy)
    else $error("transfer start not taken by the engine");

endmodule

//--- hw/dualPortRam.sv
`timescale 1ns/100ps

module dualPortRam #(
  parameter int width = 32,
  parameter int depth = 512
) (
  input  logic                     clock,
  input  logic                     writeEnableA,
  input  logic [$clog2(depth)-1:0] addressA,
  input  logic [width-1:0]         dataInA,
  output logic [width-1:0]         dataOutA,
  input  logic                     writeEnableB,
  input  logic [$clog2(depth)-1:0] addressB,
  input  logic [width-1:0]         dataInB,
  output logic [width-1:0]         dataOutB
);

  logic [width-1:0] mem [depth];

  // Both ports return the old word when reading an address being written
  always_ff @(posedge clock)
  begin
    if (writeEnableA)
    begin
      mem[addressA] <= dataInA;
    end
    if (writeEnableB)
    begin
      mem[addressB] <= dataInB;  // Port B wins a same-address collision
    end
    dataOutA <= mem[addressA];
    dataOutB <= mem[addressB];
  end

endmodule

//--- hw/dmaPkg.sv
package dmaPkg;

  localparam int ramDepth     = 512;
  localparam int ramAddrWidth = $clog2(ramDepth);
  localparam int blockWidth   = 10;
  localparam int burstWidth   = 8;  // Holds the beat count minus one

  localparam logic [7:0] customId = 8'h0C;

  // Operation field, valueA bits 12 to 9
  typedef enum logic [3:0] {
    sramRead   = 4'd0,
    sramWrite  = 4'd1,
    setBusAddr = 4'd3,
    setRamAddr = 4'd5,
    setBlock   = 4'd7,
    setBurst   = 4'd9,
    dmaControl = 4'd11
  } ciOp;

  // Read selectors sit in valueA bits 12 to 10
  localparam logic [2:0] selSram    = 3'd0;
  localparam logic [2:0] selBusAddr = 3'd1;
  localparam logic [2:0] selRamAddr = 3'd2;
  localparam logic [2:0] selBlock   = 3'd3;
  localparam logic [2:0] selBurst   = 3'd4;
  localparam logic [2:0] selStatus  = 3'd5;

  typedef enum logic [3:0] {
    idle,
    init,
    requestBus,
    setUp,
    doRead,
    waitEnd,
    doWrite,
    endError,
    endWrite
  } dmaState;

endpackage
